// File: Bender.yml
package:
  name: mem_subsys

sources:
  - src/mem_pkg.sv
  - src/lsu_ctrl.sv
  - src/lsu_datapath.sv
  - src/host_port.sv
  - src/mem_arbiter.sv
  - src/halfword_ram.sv
  - src/mem_subsys.sv
  - target: test
    files:
      - testbench/tb_mem_subsys.sv

// File: sources.f
src/mem_pkg.sv
src/lsu_ctrl.sv
src/lsu_datapath.sv
src/host_port.sv
src/mem_arbiter.sv
src/halfword_ram.sv
src/mem_subsys.sv
testbench/tb_mem_subsys.sv

// File: src/halfword_ram.sv
//==========================================================================
// halfword_ram: single-port synchronous RAM of 16-bit words with
// registered read data
//==========================================================================

module halfword_ram #(
  parameter int addr_w = 12
) (
  input  logic              clk,
  input  logic              ram_en,
  input  logic              ram_we,
  input  logic [addr_w-2:0] ram_addr,
  input  mem_pkg::half_t    ram_wdata,
  output mem_pkg::half_t    ram_rdata
);

  import mem_pkg::*;

  localparam int depth = 2 ** (addr_w - 1);   // halfwords

  half_t mem [0:depth-1];

  always_ff @(posedge clk) begin
    if (ram_en) begin
      if (ram_we) begin
        mem[ram_addr] <= ram_wdata;
      end
      ram_rdata <= mem[ram_addr];   // old contents on a write
    end
  end

endmodule

// File: src/host_port.sv
//==========================================================================
// host_port: APB slave giving test and loader access to the shared RAM
// in whole halfwords
//==========================================================================

module host_port #(
  parameter int addr_w = 12
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [addr_w-2:0] paddr,     // halfword address
  input  mem_pkg::half_t    pwdata,
  input  logic              gnt,
  input  mem_pkg::half_t    rdata,
  output mem_pkg::half_t    prdata,
  output logic              pready,
  output logic              req,
  output logic              we,
  output logic [addr_w-2:0] addr,
  output mem_pkg::half_t    wdata
);

  typedef enum logic {
    host_idle,
    host_done
  } host_state_e;

  host_state_e state_q;
  host_state_e state_d;

  always_ff @(posedge clk) begin
    if (!reset) begin
      state_q <= host_idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      host_idle: if (req && gnt) state_d = host_done;   // access taken by RAM
      default:   state_d = host_idle;
    endcase
  end

  assign req    = (state_q == host_idle) && psel && penable;
  assign we     = req && pwrite;
  assign addr   = paddr;
  assign wdata  = pwdata;
  assign pready = (state_q == host_done);
  assign prdata = rdata;              // read data lands in host_done

endmodule

// File: src/lsu_ctrl.sv
//==========================================================================
// lsu_ctrl: sequences byte, halfword and word accesses of the load/store
// port onto the halfword memory bus and steers the datapath
//==========================================================================

module lsu_ctrl #(
  parameter int addr_w = 12
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [addr_w-1:0]      paddr,      // byte address
  input  mem_pkg::access_size_e  size,
  input  logic                   sign_ext,
  input  logic                   gnt,
  output logic                   pready,
  output logic                   pslverr,
  output logic                   req,
  output logic                   we,
  output logic [addr_w-2:0]      addr,       // halfword address
  output logic                   hold_first,
  output logic                   merge_en,
  output mem_pkg::access_size_e  load_sel,
  output logic                   swap_half
);

  import mem_pkg::*;

  lsu_state_e        state_q;
  lsu_state_e        state_d;
  logic              access;
  logic              misaligned;
  logic              refuse;
  logic [addr_w-2:0] base;

  assign access = psel && penable;
  assign base   = paddr[addr_w-1:1];

  always_comb begin
    case (size)
      size_byte: misaligned = 1'b0;
      size_half: misaligned = paddr[0];
      size_word: misaligned = |paddr[1:0];
      default:   misaligned = 1'b1;   // unused size code
    endcase
  end

  // a store has nothing to extend, so a signed store is malformed
  assign refuse = misaligned || (pwrite && sign_ext);

  always_ff @(posedge clk) begin
    if (!reset) begin
      state_q <= idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      idle: begin
        if (access && !refuse && gnt) begin
          if (pwrite) begin
            case (size)
              size_byte: state_d = store_byte_a;
              size_half: state_d = store_half;
              default:   state_d = store_word_a;
            endcase
          end else begin
            case (size)
              size_byte: state_d = load_byte;
              size_half: state_d = load_half;
              default:   state_d = load_word_a;
            endcase
          end
        end
      end
      load_word_a:  if (gnt) state_d = load_word_b;
      store_word_a: if (gnt) state_d = store_word_b;
      store_byte_a: if (gnt) state_d = store_byte_b;
      default:      state_d = idle;   // completion states
    endcase
  end

  always_comb begin
    pready     = 1'b0;
    pslverr    = 1'b0;
    req        = 1'b0;
    we         = 1'b0;
    addr       = base;
    hold_first = 1'b0;
    merge_en   = 1'b0;
    load_sel   = size_word;
    swap_half  = 1'b0;
    case (state_q)
      idle: begin
        if (access && refuse) begin
          pready  = 1'b1;             // refused without touching memory
          pslverr = 1'b1;
        end else if (access) begin
          req = 1'b1;
          we  = pwrite && (size != size_byte);   // byte store reads first
        end
      end
      load_half: begin
        pready   = 1'b1;
        load_sel = size_half;
      end
      load_byte: begin
        pready   = 1'b1;
        load_sel = size_byte;
      end
      load_word_a: begin
        req        = 1'b1;
        addr       = base + 1'b1;     // high half
        hold_first = 1'b1;
      end
      store_word_a: begin
        req       = 1'b1;
        we        = 1'b1;
        addr      = base + 1'b1;
        swap_half = 1'b1;             // pwdata upper half
      end
      store_byte_a: begin
        req      = 1'b1;
        we       = 1'b1;
        merge_en = 1'b1;
      end
      load_word_b,
      store_half,
      store_word_b,
      store_byte_b: pready = 1'b1;
      default: ;
    endcase
  end

endmodule

// File: src/lsu_datapath.sv
//==========================================================================
// lsu_datapath: assembles load results from memory halfwords and builds
// the halfword written for stores
//==========================================================================

module lsu_datapath (
  input  logic                  clk,
  input  logic                  reset,
  input  mem_pkg::word_t        pwdata,
  input  logic                  byte_sel,     // byte address bit 0
  input  logic                  sign_ext,
  input  mem_pkg::half_t        rdata,
  input  logic                  hold_first,
  input  logic                  merge_en,
  input  mem_pkg::access_size_e load_sel,
  input  logic                  swap_half,
  output mem_pkg::word_t        prdata,
  output mem_pkg::half_t        wdata
);

  import mem_pkg::*;

  half_t first_q;      // low half of a word load
  byte_t sel_byte;
  byte_t st_byte;
  logic  byte_fill;
  logic  half_fill;

  always_ff @(posedge clk) begin
    if (!reset) begin
      first_q <= '0;
    end else if (hold_first) begin
      first_q <= rdata;
    end
  end

  // little endian, odd address is the upper byte
  assign sel_byte  = byte_sel ? rdata[15:8] : rdata[7:0];
  assign byte_fill = sign_ext && sel_byte[7];
  assign half_fill = sign_ext && rdata[15];

  always_comb begin
    case (load_sel)
      size_byte: prdata = {{24{byte_fill}}, sel_byte};
      size_half: prdata = {{16{half_fill}}, rdata};
      default:   prdata = {rdata, first_q};   // high half arrives last
    endcase
  end

  assign st_byte = pwdata[7:0];

  always_comb begin
    if (merge_en) begin
      // keep the neighbour byte of the halfword just read
      if (byte_sel) begin
        wdata = {st_byte, rdata[7:0]};
      end else begin
        wdata = {rdata[15:8], st_byte};
      end
    end else if (swap_half) begin
      wdata = pwdata[31:16];
    end else begin
      wdata = pwdata[15:0];
    end
  end

endmodule

// File: src/mem_arbiter.sv
//==========================================================================
// mem_arbiter: round-robin arbiter between the load/store unit and the
// host port, holding the grant while the owner keeps requesting
//==========================================================================

module mem_arbiter #(
  parameter int addr_w = 12
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              lsu_req,
  input  logic              lsu_we,
  input  logic [addr_w-2:0] lsu_addr,
  input  mem_pkg::half_t    lsu_wdata,
  input  logic              host_req,
  input  logic              host_we,
  input  logic [addr_w-2:0] host_addr,
  input  mem_pkg::half_t    host_wdata,
  output logic              lsu_gnt,
  output logic              host_gnt,
  output logic              ram_en,
  output logic              ram_we,
  output logic [addr_w-2:0] ram_addr,
  output mem_pkg::half_t    ram_wdata
);

  logic [1:0] owner_q;       // bit 0 lsu, bit 1 host, zero when free
  logic       last_host_q;   // host was served last
  logic [1:0] gnt;

  always_comb begin
    if (owner_q[0] && lsu_req) begin
      gnt = 2'b01;
    end else if (owner_q[1] && host_req) begin
      gnt = 2'b10;
    end else if (lsu_req && host_req) begin
      gnt = last_host_q ? 2'b01 : 2'b10;
    end else begin
      gnt = {host_req, lsu_req};
    end
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      owner_q     <= 2'b00;
      last_host_q <= 1'b1;   // lsu wins the first tie
    end else begin
      owner_q <= gnt;
      if (gnt != 2'b00) begin
        last_host_q <= gnt[1];
      end
    end
  end

  assign lsu_gnt   = gnt[0];
  assign host_gnt  = gnt[1];
  assign ram_en    = |gnt;
  assign ram_we    = gnt[1] ? host_we : (gnt[0] && lsu_we);
  assign ram_addr  = gnt[1] ? host_addr : lsu_addr;
  assign ram_wdata = gnt[1] ? host_wdata : lsu_wdata;

endmodule

// File: src/mem_pkg.sv
//==========================================================================
// mem_pkg: shared widths, access sizes and load/store FSM states
//==========================================================================

package mem_pkg;

  // data widths
  typedef logic [31:0] word_t;   // core register word
  typedef logic [15:0] half_t;   // one memory location
  typedef logic [7:0]  byte_t;

  // access size sideband of the load/store port
  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } access_size_e;

  // load/store sequencing states, loads have bit 3 clear
  typedef enum logic [3:0] {
    idle         = 4'b0000,
    load_half    = 4'b0001,
    load_byte    = 4'b0010,
    load_word_a  = 4'b0011,   // low half returning, high half read
    load_word_b  = 4'b0100,
    store_half   = 4'b1111,
    store_byte_a = 4'b1011,   // old halfword returning, merged write
    store_byte_b = 4'b1010,
    store_word_a = 4'b1101,   // high half written
    store_word_b = 4'b1100
  } lsu_state_e;

endpackage

// File: src/mem_subsys.sv
//==========================================================================
// mem_subsys: load/store unit and host port sharing one halfword RAM
//==========================================================================

module mem_subsys #(
  parameter int addr_w = 12
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  lsu_psel,
  input  logic                  lsu_penable,
  input  logic                  lsu_pwrite,
  input  logic [addr_w-1:0]     lsu_paddr,
  input  mem_pkg::word_t        lsu_pwdata,
  input  mem_pkg::access_size_e lsu_size,
  input  logic                  lsu_sign_ext,
  output mem_pkg::word_t        lsu_prdata,
  output logic                  lsu_pready,
  output logic                  lsu_pslverr,
  input  logic                  host_psel,
  input  logic                  host_penable,
  input  logic                  host_pwrite,
  input  logic [addr_w-2:0]     host_paddr,
  input  mem_pkg::half_t        host_pwdata,
  output mem_pkg::half_t        host_prdata,
  output logic                  host_pready
);

  import mem_pkg::*;

  logic              lsu_req;
  logic              lsu_we;
  logic [addr_w-2:0] lsu_addr;
  half_t             lsu_wdata;
  logic              lsu_gnt;
  logic              hold_first;
  logic              merge_en;
  access_size_e      load_sel;
  logic              swap_half;
  logic              host_req;
  logic              host_we;
  logic [addr_w-2:0] host_addr;
  half_t             host_wdata;
  logic              host_gnt;
  logic              ram_en;
  logic              ram_we;
  logic [addr_w-2:0] ram_addr;
  half_t             ram_wdata;
  half_t             ram_rdata;

  lsu_ctrl #(
    .addr_w (addr_w)
  ) u_lsu_ctrl (
    .clk        (clk),
    .reset      (reset),
    .psel       (lsu_psel),
    .penable    (lsu_penable),
    .pwrite     (lsu_pwrite),
    .paddr      (lsu_paddr),
    .size       (lsu_size),
    .sign_ext   (lsu_sign_ext),
    .gnt        (lsu_gnt),
    .pready     (lsu_pready),
    .pslverr    (lsu_pslverr),
    .req        (lsu_req),
    .we         (lsu_we),
    .addr       (lsu_addr),
    .hold_first (hold_first),
    .merge_en   (merge_en),
    .load_sel   (load_sel),
    .swap_half  (swap_half)
  );

  lsu_datapath u_lsu_datapath (
    .clk        (clk),
    .reset      (reset),
    .pwdata     (lsu_pwdata),
    .byte_sel   (lsu_paddr[0]),
    .sign_ext   (lsu_sign_ext),
    .rdata      (ram_rdata),
    .hold_first (hold_first),
    .merge_en   (merge_en),
    .load_sel   (load_sel),
    .swap_half  (swap_half),
    .prdata     (lsu_prdata),
    .wdata      (lsu_wdata)
  );

  host_port #(
    .addr_w (addr_w)
  ) u_host_port (
    .clk     (clk),
    .reset   (reset),
    .psel    (host_psel),
    .penable (host_penable),
    .pwrite  (host_pwrite),
    .paddr   (host_paddr),
    .pwdata  (host_pwdata),
    .gnt     (host_gnt),
    .rdata   (ram_rdata),
    .prdata  (host_prdata),
    .pready  (host_pready),
    .req     (host_req),
    .we      (host_we),
    .addr    (host_addr),
    .wdata   (host_wdata)
  );

  mem_arbiter #(
    .addr_w (addr_w)
  ) u_mem_arbiter (
    .clk        (clk),
    .reset      (reset),
    .lsu_req    (lsu_req),
    .lsu_we     (lsu_we),
    .lsu_addr   (lsu_addr),
    .lsu_wdata  (lsu_wdata),
    .host_req   (host_req),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .lsu_gnt    (lsu_gnt),
    .host_gnt   (host_gnt),
    .ram_en     (ram_en),
    .ram_we     (ram_we),
    .ram_addr   (ram_addr),
    .ram_wdata  (ram_wdata)
  );

  halfword_ram #(
    .addr_w (addr_w)
  ) u_halfword_ram (
    .clk       (clk),
    .ram_en    (ram_en),
    .ram_we    (ram_we),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_rdata (ram_rdata)
  );

endmodule

// File: testbench/tb_mem_subsys.sv
//==========================================================================
// tb_mem_subsys: drives both APB ports of the memory subsystem and checks
// loads and host reads against a halfword reference model
//==========================================================================

module tb_mem_subsys;

  import mem_pkg::*;

  localparam int addr_w       = 12;
  localparam int reset_cycles = 10;
  localparam int op_bound     = 20;    // cycles allowed per operation
  localparam int n_directed   = 40;
  localparam int n_preload    = 128;
  localparam int n_random     = 40;    // per port, run side by side
  localparam int total_ops    = n_directed + n_preload + 2 * n_random;

  logic              clk;
  logic              reset;
  logic              lsu_psel;
  logic              lsu_penable;
  logic              lsu_pwrite;
  logic [addr_w-1:0] lsu_paddr;
  word_t             lsu_pwdata;
  access_size_e      lsu_size;
  logic              lsu_sign_ext;
  word_t             lsu_prdata;
  logic              lsu_pready;
  logic              lsu_pslverr;
  logic              host_psel;
  logic              host_penable;
  logic              host_pwrite;
  logic [addr_w-2:0] host_paddr;
  half_t             host_pwdata;
  half_t             host_prdata;
  logic              host_pready;

  integer            seed;
  logic              uncontended;   // one port active, latency is fixed
  half_t             model [0:2**(addr_w-1)-1];   // mirror of the RAM
  string             name_q[$];
  logic [31:0]       exp_q[$];
  logic [31:0]       act_q[$];

  mem_subsys #(
    .addr_w (addr_w)
  ) u_dut (
    .clk          (clk),
    .reset        (reset),
    .lsu_psel     (lsu_psel),
    .lsu_penable  (lsu_penable),
    .lsu_pwrite   (lsu_pwrite),
    .lsu_paddr    (lsu_paddr),
    .lsu_pwdata   (lsu_pwdata),
    .lsu_size     (lsu_size),
    .lsu_sign_ext (lsu_sign_ext),
    .lsu_prdata   (lsu_prdata),
    .lsu_pready   (lsu_pready),
    .lsu_pslverr  (lsu_pslverr),
    .host_psel    (host_psel),
    .host_penable (host_penable),
    .host_pwrite  (host_pwrite),
    .host_paddr   (host_paddr),
    .host_pwdata  (host_pwdata),
    .host_prdata  (host_prdata),
    .host_pready  (host_pready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // expected load value, little endian, from the model contents
  function automatic word_t expected_load(input access_size_e sz, input logic sgn,
                                          input logic [addr_w-1:0] a);
    half_t lo;
    half_t hi;
    byte_t b;
    word_t res;
    lo = model[a[addr_w-1:1]];
    hi = model[a[addr_w-1:1] + 1'b1];
    b  = a[0] ? lo[15:8] : lo[7:0];
    case (sz)
      size_byte: res = {{24{sgn & b[7]}}, b};
      size_half: res = {{16{sgn & lo[15]}}, lo};
      default:   res = {hi, lo};
    endcase
    return res;
  endfunction

  task automatic store_model(input access_size_e sz, input logic [addr_w-1:0] a,
                             input word_t wd);
    logic [addr_w-2:0] h;
    h = a[addr_w-1:1];
    case (sz)
      size_byte: begin
        if (a[0]) model[h][15:8] = wd[7:0];
        else model[h][7:0] = wd[7:0];
      end
      size_half: model[h] = wd[15:0];
      default: begin
        model[h]        = wd[15:0];
        model[h + 1'b1] = wd[31:16];
      end
    endcase
  endtask

  task automatic push_check(input string name, input logic [31:0] exp, input logic [31:0] act);
    name_q.push_back(name);
    exp_q.push_back(exp);
    act_q.push_back(act);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("Error at time %0t: %s expected %h, actual %h", $time, name, exp, act);
      $display("Regression failed");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  always @(negedge clk) begin : compare_proc
    string       n;
    logic [31:0] e;
    logic [31:0] a;
    while (exp_q.size() > 0) begin
      n = name_q.pop_front();
      e = exp_q.pop_front();
      a = act_q.pop_front();
      check_value(n, e, a);
    end
  end

  task automatic lsu_access(input logic write, input access_size_e sz, input logic sgn,
                            input logic [addr_w-1:0] a, input word_t wd, input logic exp_err);
    word_t rd;
    logic  err;
    int    cycles;
    int    exp_cycles;
    @(posedge clk);
    #10;
    lsu_psel     = 1'b1;   // setup phase
    lsu_penable  = 1'b0;
    lsu_pwrite   = write;
    lsu_paddr    = a;
    lsu_pwdata   = wd;
    lsu_size     = sz;
    lsu_sign_ext = sgn;
    @(posedge clk);
    #10;
    lsu_penable = 1'b1;
    cycles      = 0;
    @(negedge clk);
    while (!lsu_pready) begin
      @(negedge clk);
      cycles++;
    end
    rd  = lsu_prdata;
    err = lsu_pslverr;
    @(posedge clk);
    #10;
    lsu_psel    = 1'b0;
    lsu_penable = 1'b0;
    // first access cycle counts as cycle 0
    if (exp_err) exp_cycles = 0;
    else if (sz == size_word || (write && sz == size_byte)) exp_cycles = 2;
    else exp_cycles = 1;
    if (uncontended) push_check("lsu_pready", exp_cycles, cycles);
    push_check("lsu_pslverr", {31'b0, exp_err}, {31'b0, err});
    if (!exp_err && write) store_model(sz, a, wd);
    if (!exp_err && !write) push_check("lsu_prdata", expected_load(sz, sgn, a), rd);
  endtask

  task automatic host_access(input logic write, input logic [addr_w-2:0] a, input half_t wd);
    half_t rd;
    int    cycles;
    @(posedge clk);
    #10;
    host_psel    = 1'b1;
    host_penable = 1'b0;
    host_pwrite  = write;
    host_paddr   = a;
    host_pwdata  = wd;
    @(posedge clk);
    #10;
    host_penable = 1'b1;
    cycles       = 0;
    @(negedge clk);
    while (!host_pready) begin
      @(negedge clk);
      cycles++;
    end
    rd = host_prdata;
    @(posedge clk);
    #10;
    host_psel    = 1'b0;
    host_penable = 1'b0;
    if (uncontended) push_check("host_pready", 32'd1, cycles);
    if (write) model[a] = wd;
    else push_check("host_prdata", {16'h0, model[a]}, {16'h0, rd});
  endtask

  // lsu side works in halfwords 0 to 63
  task automatic run_lsu_random(input int count);
    logic [1:0]        pick;
    logic              write;
    logic              sgn;
    access_size_e      sz;
    logic [addr_w-1:0] a;
    word_t             wd;
    for (int n = 0; n < count; n++) begin
      pick  = $random(seed);
      write = $random(seed);
      sgn   = $random(seed);
      a     = $random(seed) & 'h7f;
      wd    = $random(seed);
      case (pick)
        2'd0:    sz = size_byte;
        2'd1:    sz = size_half;
        default: sz = size_word;
      endcase
      if (sz == size_half) a[0] = 1'b0;
      if (sz == size_word) a[1:0] = 2'b00;
      if (write) sgn = 1'b0;   // stores carry no extension
      lsu_access(write, sz, sgn, a, wd, 1'b0);
    end
  endtask

  // host side works in halfwords 64 to 127
  task automatic run_host_random(input int count);
    logic              write;
    logic [addr_w-2:0] a;
    half_t             wd;
    for (int n = 0; n < count; n++) begin
      write = $random(seed);
      a     = 64 + ($random(seed) & 63);
      wd    = $random(seed);
      host_access(write, a, wd);
    end
  endtask

  initial begin
    repeat (reset_cycles + total_ops * op_bound) @(posedge clk);
    $display("Timeout: the operations did not complete within the watchdog limit");
    $display("Regression failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    int i;
    int s;
    seed         = 32'hc6db;
    uncontended  = 1'b1;
    reset        = 1'b0;
    lsu_psel     = 1'b0;
    lsu_penable  = 1'b0;
    lsu_pwrite   = 1'b0;
    lsu_paddr    = '0;
    lsu_pwdata   = '0;
    lsu_size     = size_byte;
    lsu_sign_ext = 1'b0;
    host_psel    = 1'b0;
    host_penable = 1'b0;
    host_pwrite  = 1'b0;
    host_paddr   = '0;
    host_pwdata  = '0;
    repeat (reset_cycles) @(posedge clk);
    #10;
    reset = 1'b1;

    // word store, word load, then both halves through the host
    lsu_access(1'b1, size_word, 1'b0, 12'h010, 32'h89ab_4567, 1'b0);
    lsu_access(1'b0, size_word, 1'b0, 12'h010, 32'h0, 1'b0);
    host_access(1'b0, 11'h008, 16'h0);
    host_access(1'b0, 11'h009, 16'h0);

    // narrow loads, top bits set and clear
    host_access(1'b1, 11'h020, 16'h80f1);
    host_access(1'b1, 11'h021, 16'h7f12);
    for (s = 0; s < 2; s++) begin
      lsu_access(1'b0, size_half, s[0], 12'h040, 32'h0, 1'b0);
      lsu_access(1'b0, size_half, s[0], 12'h042, 32'h0, 1'b0);
      for (i = 0; i < 4; i++) begin
        lsu_access(1'b0, size_byte, s[0], 12'h040 + i, 32'h0, 1'b0);
      end
    end

    // byte stores keep the neighbour byte
    host_access(1'b1, 11'h022, 16'h1234);
    host_access(1'b1, 11'h023, 16'h5678);
    lsu_access(1'b1, size_byte, 1'b0, 12'h045, 32'h0000_00ab, 1'b0);
    lsu_access(1'b1, size_byte, 1'b0, 12'h046, 32'hffff_ffcd, 1'b0);
    host_access(1'b0, 11'h022, 16'h0);
    host_access(1'b0, 11'h023, 16'h0);

    // misaligned requests are refused and leave memory alone
    host_access(1'b1, 11'h028, 16'ha5a5);
    host_access(1'b1, 11'h029, 16'h3c3c);
    host_access(1'b1, 11'h02a, 16'h0ff0);
    lsu_access(1'b1, size_half, 1'b0, 12'h051, 32'hffff_ffff, 1'b1);
    lsu_access(1'b1, size_word, 1'b0, 12'h052, 32'hffff_ffff, 1'b1);
    lsu_access(1'b1, size_word, 1'b0, 12'h053, 32'hffff_ffff, 1'b1);
    lsu_access(1'b0, size_half, 1'b1, 12'h053, 32'h0, 1'b1);
    lsu_access(1'b0, size_word, 1'b0, 12'h056, 32'h0, 1'b1);
    host_access(1'b0, 11'h028, 16'h0);
    host_access(1'b0, 11'h029, 16'h0);
    host_access(1'b0, 11'h02a, 16'h0);

    // preload both regions, then run the ports against each other
    for (i = 0; i < n_preload; i++) begin
      host_access(1'b1, i[addr_w-2:0], half_t'($random(seed)));
    end
    uncontended = 1'b0;
    fork
      run_lsu_random(n_random);
      run_host_random(n_random);
    join

    repeat (2) @(posedge clk);   // let the compare process drain
    $display("Regression passed");
    $finish;
  end

endmodule
